// File: include/fpu_defines.svh
// single precision field widths, exponent constants, opcodes and the canonical quiet NaN
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// ieee 754 single precision layout
`define FPU_WORD_W 32
`define FPU_EXP_W  8
`define FPU_FRAC_W 23

// mantissa with hidden bit
`define FPU_MANT_W 24
// mantissa with guard, round and sticky appended
`define FPU_EXT_W  27

`define FPU_BIAS    127
`define FPU_EXP_MAX 255

// opcode encoding
`define FPU_OP_ADD 2'b00
`define FPU_OP_SUB 2'b01
`define FPU_OP_RSV 2'b10
`define FPU_OP_MUL 2'b11

// result for the reserved opcode
`define FPU_QNAN 32'h7FC0_0000

`endif

// File: logic/fpu_pkg.sv
// float field struct, float word union and opcode enum
`include "fpu_defines.svh"

package fpu_pkg;

	typedef struct packed {
		logic                   sign;
		logic [`FPU_EXP_W-1:0]  exp;
		logic [`FPU_FRAC_W-1:0] frac;
	} float_fields_t;

	// raw word for constant compares, fields for arithmetic
	typedef union packed {
		logic [`FPU_WORD_W-1:0] word;
		float_fields_t          f;
	} float_t;

	typedef enum logic [1:0] {
		op_add = `FPU_OP_ADD,
		op_sub = `FPU_OP_SUB,
		op_rsv = `FPU_OP_RSV,
		op_mul = `FPU_OP_MUL
	} fpu_op_t;

endpackage

// File: logic/fpu_special_case.sv
// NaN, zero and infinity detection on both operands and special-case result select
`include "fpu_defines.svh"

module fpu_special_case (
	input  fpu_pkg::float_t i_a,
	input  fpu_pkg::float_t i_b,
	input  logic            i_is_mul,
	output logic            o_hit,
	output fpu_pkg::float_t o_value
);
	import fpu_pkg::*;

	localparam logic [`FPU_EXP_W-1:0] exp_ones = `FPU_EXP_MAX;
	// anything above the infinity magnitude is NaN
	localparam logic [`FPU_WORD_W-2:0] inf_mag = {exp_ones, {`FPU_FRAC_W{1'b0}}};

	logic   a_zero;
	logic   a_inf;
	logic   a_nan;
	logic   b_zero;
	logic   b_inf;
	logic   b_nan;
	logic   sign_x;
	float_t zero_val;
	float_t inf_val;

	assign a_zero = (i_a.word[`FPU_WORD_W-2:0] == '0);
	assign a_inf  = (i_a.word[`FPU_WORD_W-2:0] == inf_mag);
	assign a_nan  = (i_a.word[`FPU_WORD_W-2:0] > inf_mag);
	assign b_zero = (i_b.word[`FPU_WORD_W-2:0] == '0);
	assign b_inf  = (i_b.word[`FPU_WORD_W-2:0] == inf_mag);
	assign b_nan  = (i_b.word[`FPU_WORD_W-2:0] > inf_mag);

	// multiply results carry the product sign
	assign sign_x        = i_a.f.sign ^ i_b.f.sign;
	assign zero_val.word = {sign_x, {(`FPU_WORD_W-1){1'b0}}};
	assign inf_val.word  = {sign_x, inf_mag};

	always_comb begin
		o_hit   = 1'b1;
		o_value = i_a;
		if (i_is_mul) begin
			if (a_nan) begin
				o_value = i_a;
			end else if (b_nan) begin
				o_value = i_b;
			end else if (a_zero || b_zero) begin
				o_value = zero_val;
			end else if (a_inf || b_inf) begin
				o_value = inf_val;
			end else begin
				o_hit = 1'b0;
			end
		end else begin
			// b here is already negated for subtract
			if (a_nan || b_zero) begin
				o_value = i_a;
			end else if (b_nan || a_zero) begin
				o_value = i_b;
			end else if (a_inf) begin
				o_value = i_a;
			end else if (b_inf) begin
				o_value = i_b;
			end else begin
				o_hit = 1'b0;
			end
		end
	end

endmodule

// File: logic/fpu_add_round.sv
// leading-zero normalise, round to nearest-even with carry renormalise, and pack
`include "fpu_defines.svh"

module fpu_add_round (
	input  logic                i_sign,
	input  logic [`FPU_EXP_W:0] i_exp,
	input  logic [`FPU_EXT_W:0] i_mant,
	output fpu_pkg::float_t     o_sum
);
	import fpu_pkg::*;

	logic [4:0]             lead;
	logic [4:0]             shift;
	logic [`FPU_EXT_W:0]    norm;
	logic [`FPU_EXP_W:0]    norm_exp;
	logic                   inc;
	logic [`FPU_MANT_W:0]   rounded;
	logic [`FPU_EXP_W:0]    res_exp;
	logic [`FPU_FRAC_W-1:0] res_frac;
	float_t                 packed_sum;

	// find the highest set bit for the shift up to EXT_W-1
	always_comb begin
		lead = '0;
		for (int i = 0; i < `FPU_EXT_W; i++) begin
			if (i_mant[i]) begin
				lead = 5'(i);
			end
		end
	end

	assign shift    = 5'(`FPU_EXT_W - 1) - lead;
	assign norm     = i_mant << shift;
	assign norm_exp = i_exp - {{(`FPU_EXP_W-4){1'b0}}, shift};

	// guard set and anything else set, or a tie with odd lsb
	assign inc     = norm[2] & (norm[1] | norm[0] | norm[3]);
	assign rounded = norm[`FPU_EXT_W:3] + {{`FPU_MANT_W{1'b0}}, inc};

	always_comb begin
		if (rounded[`FPU_MANT_W]) begin
			res_frac = rounded[`FPU_MANT_W-1:1];
			res_exp  = norm_exp + 1'b1;
		end else begin
			res_frac = rounded[`FPU_FRAC_W-1:0];
			res_exp  = norm_exp;
		end
	end

	// exact cancellation gives +0
	always_comb begin
		if (i_mant == '0) begin
			packed_sum = '0;
		end else begin
			packed_sum.f.sign = i_sign;
			packed_sum.f.exp  = res_exp[`FPU_EXP_W-1:0];
			packed_sum.f.frac = res_frac;
		end
	end

	assign o_sum = packed_sum;

endmodule

// File: logic/fpu_adder.sv
// operand unpack, exponent compare, aligned shift with sticky and signed mantissa add
`include "fpu_defines.svh"

module fpu_adder (
	input  fpu_pkg::float_t     i_a,
	input  fpu_pkg::float_t     i_b,
	output logic                o_sign,
	output logic [`FPU_EXP_W:0] o_exp,
	output logic [`FPU_EXT_W:0] o_mant,
	output fpu_pkg::float_t     o_sum
);
	import fpu_pkg::*;

	// subnormals are unpacked with exponent 1
	localparam logic [`FPU_EXP_W-1:0] exp_sub = 1;
	localparam int wide_w = `FPU_MANT_W + `FPU_EXT_W - 1;

	logic                   a_big;
	float_t                 big_op;
	float_t                 small_op;
	logic [`FPU_EXP_W-1:0]  big_exp;
	logic [`FPU_EXP_W-1:0]  small_exp;
	logic [`FPU_MANT_W-1:0] big_mant;
	logic [`FPU_MANT_W-1:0] small_mant;
	logic [`FPU_EXP_W-1:0]  diff;
	logic [wide_w-1:0]      wide;
	logic [`FPU_EXT_W-1:0]  big_ext;
	logic [`FPU_EXT_W-1:0]  small_ext;
	logic [`FPU_EXT_W:0]    raw;

	// magnitude order is plain integer order of the low 31 bits
	assign a_big    = (i_a.word[`FPU_WORD_W-2:0] >= i_b.word[`FPU_WORD_W-2:0]);
	assign big_op   = a_big ? i_a : i_b;
	assign small_op = a_big ? i_b : i_a;

	assign big_exp    = (big_op.f.exp == '0) ? exp_sub : big_op.f.exp;
	assign small_exp  = (small_op.f.exp == '0) ? exp_sub : small_op.f.exp;
	assign big_mant   = {|big_op.f.exp, big_op.f.frac};
	assign small_mant = {|small_op.f.exp, small_op.f.frac};

	assign diff    = big_exp - small_exp;
	assign big_ext = {big_mant, 3'b000};

	// align smaller operand and fold bits below round into sticky
	always_comb begin
		wide = {small_mant, {(`FPU_EXT_W-1){1'b0}}} >> diff;
		if (diff > (`FPU_EXT_W - 1)) begin
			small_ext = {{(`FPU_EXT_W-1){1'b0}}, |small_mant};
		end else begin
			small_ext = {wide[wide_w-1 -: `FPU_EXT_W-1], |wide[`FPU_MANT_W-1:0]};
		end
	end

	always_comb begin
		if (big_op.f.sign == small_op.f.sign) begin
			raw = {1'b0, big_ext} + {1'b0, small_ext};
		end else begin
			raw = {1'b0, big_ext} - {1'b0, small_ext};
		end
	end

	// carry out halves the sum, keeping sticky
	always_comb begin
		if (raw[`FPU_EXT_W]) begin
			o_mant = {1'b0, raw[`FPU_EXT_W:2], raw[1] | raw[0]};
			o_exp  = {1'b0, big_exp} + 1'b1;
		end else begin
			o_mant = raw;
			o_exp  = {1'b0, big_exp};
		end
	end

	assign o_sign = big_op.f.sign;

	fpu_add_round u_round (
		.i_sign (o_sign),
		.i_exp  (o_exp),
		.i_mant (o_mant),
		.o_sum  (o_sum)
	);

endmodule

// File: logic/fpu_multiplier.sv
// operand unpack, biased exponent sum, mantissa product, normalise and truncate
`include "fpu_defines.svh"

module fpu_multiplier (
	input  fpu_pkg::float_t i_a,
	input  fpu_pkg::float_t i_b,
	output fpu_pkg::float_t o_product
);
	import fpu_pkg::*;

	localparam int prod_w = 2 * `FPU_MANT_W;
	localparam logic [`FPU_EXP_W-1:0] exp_sub = 1;
	localparam logic [`FPU_EXP_W+1:0] bias = `FPU_BIAS;

	logic [`FPU_EXP_W-1:0]  a_exp;
	logic [`FPU_EXP_W-1:0]  b_exp;
	logic [`FPU_MANT_W-1:0] a_mant;
	logic [`FPU_MANT_W-1:0] b_mant;
	logic [prod_w-1:0]      product;
	logic [`FPU_EXP_W+1:0]  exp_sum;
	logic [5:0]             lead;
	logic [5:0]             lshift;
	logic [prod_w-1:0]      norm;
	logic [`FPU_EXP_W+1:0]  res_exp;
	float_t                 res;

	assign a_exp  = (i_a.f.exp == '0) ? exp_sub : i_a.f.exp;
	assign b_exp  = (i_b.f.exp == '0) ? exp_sub : i_b.f.exp;
	assign a_mant = {|i_a.f.exp, i_a.f.frac};
	assign b_mant = {|i_b.f.exp, i_b.f.frac};

	assign product = a_mant * b_mant;
	assign exp_sum = {2'b00, a_exp} + {2'b00, b_exp} - bias;

	always_comb begin
		lead = '0;
		for (int i = 0; i < prod_w; i++) begin
			if (product[i]) begin
				lead = 6'(i);
			end
		end
	end

	// left shift only matters for subnormal operands
	assign lshift = 6'(prod_w - 2) - lead;

	always_comb begin
		if (product[prod_w-1]) begin
			norm    = product >> 1;
			res_exp = exp_sum + 1'b1;
		end else begin
			norm    = product << lshift;
			res_exp = exp_sum - {{(`FPU_EXP_W-4){1'b0}}, lshift};
		end
	end

	// product is truncated without rounding
	always_comb begin
		res.f.sign = i_a.f.sign ^ i_b.f.sign;
		res.f.exp  = res_exp[`FPU_EXP_W-1:0];
		res.f.frac = norm[prod_w-3 -: `FPU_FRAC_W];
	end

	assign o_product = res;

endmodule

// File: logic/fpu_top.sv
// opcode decode, subtract operand negation, result select and output register
`include "fpu_defines.svh"

module fpu_top (
	input  logic             clk,
	input  logic             i_rst_n,
	input  fpu_pkg::fpu_op_t i_op,
	input  fpu_pkg::float_t  i_a,
	input  fpu_pkg::float_t  i_b,
	output fpu_pkg::float_t  o_result
);
	import fpu_pkg::*;

	logic   is_sub;
	logic   is_mul;
	float_t eff_b;
	logic   sc_hit;
	float_t sc_value;
	float_t sum;
	float_t product;
	float_t next_result;

	assign is_sub = (i_op == op_sub);
	assign is_mul = (i_op == op_mul);

	// subtract is add with b negated
	always_comb begin
		eff_b        = i_b;
		eff_b.f.sign = i_b.f.sign ^ is_sub;
	end

	fpu_special_case u_special (
		.i_a      (i_a),
		.i_b      (eff_b),
		.i_is_mul (is_mul),
		.o_hit    (sc_hit),
		.o_value  (sc_value)
	);

	fpu_adder u_adder (
		.i_a    (i_a),
		.i_b    (eff_b),
		.o_sign (),
		.o_exp  (),
		.o_mant (),
		.o_sum  (sum)
	);

	fpu_multiplier u_mult (
		.i_a       (i_a),
		.i_b       (i_b),
		.o_product (product)
	);

	always_comb begin
		case (i_op)
			op_rsv:  next_result = `FPU_QNAN;
			op_mul:  next_result = sc_hit ? sc_value : product;
			default: next_result = sc_hit ? sc_value : sum;
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_result <= '0;
		end else begin
			o_result <= next_result;
		end
	end

endmodule

// File: dv/fpu_assertions.sv
// bound concurrent checks of reset value, known output and reserved opcode result
`include "fpu_defines.svh"

module fpu_assertions (
	input logic             clk,
	input logic             i_rst_n,
	input fpu_pkg::fpu_op_t i_op,
	input fpu_pkg::float_t  i_result
);
	import fpu_pkg::*;

	// register cleared on any edge seen with reset low
	reset_value: assert property (@(posedge clk) !i_rst_n |=> (i_result.word == '0))
		else $error("result register not cleared by reset");

	known_result: assert property (@(posedge clk) disable iff (!i_rst_n)
		!$isunknown(i_result.word))
		else $error("result register holds unknown bits after reset");

	// reserved code gives the canonical quiet NaN one cycle later
	reserved_nan: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_op == op_rsv) |=> (i_result.word == `FPU_QNAN))
		else $error("reserved opcode did not produce the canonical quiet NaN");

endmodule

bind fpu_top fpu_assertions u_assertions (
	.clk      (clk),
	.i_rst_n  (i_rst_n),
	.i_op     (i_op),
	.i_result (o_result)
);

// File: dv/fpu_tb.sv
// clock, reset, case-file stimulus, result checks, commutativity test and watchdog for the fpu
`include "fpu_defines.svh"

module fpu_tb;
	import fpu_pkg::*;

	localparam int clk_period   = 40;
	localparam int reset_cycles = 8;
	localparam int rand_pairs   = 8;
	localparam int max_cases    = 64;
	// what the in-flight record is compared against
	localparam int kind_none    = 0;
	localparam int kind_fixed   = 1;
	localparam int kind_prev    = 2;
	localparam int kind_record  = 3;

	logic        clk;
	logic        i_rst_n;
	fpu_op_t     i_op;
	logic [31:0] i_a;
	logic [31:0] i_b;
	logic [31:0] o_result;

	logic [1:0]     case_op [max_cases];
	logic [31:0]    case_a [max_cases];
	logic [31:0]    case_b [max_cases];
	logic [31:0]    case_exp [max_cases];
	int             num_cases;
	reg [8*160-1:0] line_buf;

	int          pend_kind;
	logic [1:0]  pend_op;
	logic [31:0] pend_a;
	logic [31:0] pend_b;
	logic [31:0] pend_exp;
	logic [31:0] last_seen;

	int          checks;
	int          errors;
	int          group_checks;
	int          group_errors;
	int          watch_limit = 0;
	integer      seed;
	logic [31:0] rand_a;
	logic [31:0] rand_b;

	fpu_top DUT (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_op     (i_op),
		.i_a      (i_a),
		.i_b      (i_b),
		.o_result (o_result)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	task automatic load_cases();
		integer      fd;
		integer      n;
		logic [31:0] f_op;
		logic [31:0] f_a;
		logic [31:0] f_b;
		logic [31:0] f_exp;
		num_cases = 0;
		fd = $fopen("dv/fpu_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file dv/fpu_cases.txt");
			errors++;
		end else begin
			while ($fgets(line_buf, fd) != 0) begin
				// comment and blank lines do not scan as four fields
				n = $sscanf(line_buf, "%h %h %h %h", f_op, f_a, f_b, f_exp);
				if (n == 4 && num_cases < max_cases) begin
					case_op[num_cases]  = f_op[1:0];
					case_a[num_cases]   = f_a;
					case_b[num_cases]   = f_b;
					case_exp[num_cases] = f_exp;
					num_cases++;
				end
			end
			$fclose(fd);
		end
	endtask

	// compares the operation driven one edge earlier
	task automatic check_result();
		logic [31:0] expected;
		if (pend_kind == kind_fixed || pend_kind == kind_prev) begin
			expected = (pend_kind == kind_prev) ? last_seen : pend_exp;
			checks++;
			group_checks++;
			assert (o_result === expected) else begin
				$display("ERROR at time %0t: op %0d a %h b %h expected %h got %h",
					$time, pend_op, pend_a, pend_b, expected, o_result);
				errors++;
				group_errors++;
			end
		end
		last_seen = o_result;
	endtask

	task automatic apply_op(input logic [1:0] op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] exp_val, input int kind);
		@(posedge clk);
		i_op <= fpu_op_t'(op);
		i_a  <= a;
		i_b  <= b;
		@(negedge clk);
		check_result();
		pend_kind = kind;
		pend_op   = op;
		pend_a    = a;
		pend_b    = b;
		pend_exp  = exp_val;
	endtask

	task automatic flush_pending();
		@(posedge clk);
		@(negedge clk);
		check_result();
		pend_kind = kind_none;
	endtask

	task automatic report_group(input string name);
		$display("%s: %0d checks, %0d errors", name, group_checks, group_errors);
		group_checks = 0;
		group_errors = 0;
	endtask

	// normal operand with exponent in 64..190
	task automatic draw_operand(output logic [31:0] word);
		logic [31:0] r_sign;
		logic [31:0] r_exp;
		logic [31:0] r_frac;
		r_sign = $random(seed);
		r_exp  = $random(seed);
		r_frac = $random(seed);
		word = {r_sign[0], 8'(64 + (r_exp % 127)), r_frac[22:0]};
	endtask

	initial begin
		wait (watch_limit > 0);
		#(watch_limit);
		$display("TIMEOUT: run did not finish within %0d time units", watch_limit);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		i_rst_n      = 1'b0;
		i_op         = op_add;
		i_a          = 32'h3F80_0000;
		i_b          = 32'h4000_0000;
		pend_kind    = kind_none;
		last_seen    = '0;
		checks       = 0;
		errors       = 0;
		group_checks = 0;
		group_errors = 0;
		seed         = 32'h4103;
		load_cases();
		watch_limit = (num_cases + 4 * rand_pairs + reset_cycles + 20) * clk_period;

		repeat (reset_cycles) @(posedge clk);
		i_rst_n <= 1'b1;
		@(negedge clk);
		checks++;
		group_checks++;
		assert (o_result === 32'h0) else begin
			$display("ERROR at time %0t: result %h after reset, expected 0", $time, o_result);
			errors++;
			group_errors++;
		end
		report_group("reset");

		// case file ops go out on consecutive cycles
		for (int i = 0; i < num_cases; i++) begin
			apply_op(case_op[i], case_a[i], case_b[i], case_exp[i], kind_fixed);
		end
		flush_pending();
		if (num_cases == 0) begin
			$display("no cases were read from the case file");
			errors++;
		end
		report_group("case file");

		for (int p = 0; p < rand_pairs; p++) begin
			draw_operand(rand_a);
			draw_operand(rand_b);
			apply_op(`FPU_OP_ADD, rand_a, rand_b, '0, kind_record);
			apply_op(`FPU_OP_ADD, rand_b, rand_a, '0, kind_prev);
			apply_op(`FPU_OP_MUL, rand_a, rand_b, '0, kind_record);
			apply_op(`FPU_OP_MUL, rand_b, rand_a, '0, kind_prev);
		end
		flush_pending();
		report_group("commutativity");

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: sources.f
+incdir+include
logic/fpu_pkg.sv
logic/fpu_special_case.sv
logic/fpu_add_round.sv
logic/fpu_adder.sv
logic/fpu_multiplier.sv
logic/fpu_top.sv
dv/fpu_assertions.sv
dv/fpu_tb.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -Wno-fatal
TOP       := fpu_tb
FILELIST  := sources.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q '^>>> FAIL' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif ! grep -q '^>>> PASS' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/fpu_cases.txt
# columns: opcode (0 add, 1 sub, 2 reserved, 3 mul), operand a, operand b, expected result
# all values hex, one case per line
0 3F800000 40000000 40400000
0 3FA00000 3FC00000 40300000
0 3F800000 33820000 3F800001
0 3F800000 33800000 3F800000
0 3F800001 33800000 3F800002
0 3F800000 2B800000 3F800000
1 3F800000 3F7FFFFF 33800000
1 3F800000 40400000 C0000000
1 40200000 40200000 00000000
3 3FC00000 3FC00000 40100000
3 3F800001 3FC00000 3FC00001
3 C0000000 40400000 C0C00000
0 7F812345 3F800000 7F812345
0 3F800000 FFC00001 FFC00001
1 00000000 3F800000 BF800000
1 3F800000 7F800000 FF800000
3 00000000 FF800000 80000000
3 7F800000 C0000000 FF800000
3 3F800000 7FC00000 7FC00000
2 3F800000 40000000 7FC00000
